//--- Makefile
# Verilator build and run for the host catcher testbench

TOP = ahb_mmio_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f hw/*.sv test/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "Run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir $(LOG)

//--- hw/ahb_mmio_decoder.sv
// AHB-Lite host catcher decoder
// Captures address phases, decodes the TOHOST / UART map,
// pushes transmit bytes into the queue, latches the TOHOST
// result and answers status reads. Unmapped accesses get a
// two-cycle ERROR response
module ahb_mmio_decoder
  import mmio_pkg::*;
(
  input  logic      HCLK,
  input  logic      rst_n_i,

  // AHB-Lite slave side
  input  logic      HSEL_i,
  input  haddr_t    HADDR_i,
  input  htrans_e   HTRANS_i,
  input  logic      HWRITE_i,
  input  hsize_t    HSIZE_i,
  input  hdata_t    HWDATA_i,
  input  logic      HREADY_i,
  output logic      HREADYOUT_o,
  output logic      HRESP_o,
  output hdata_t    HRDATA_o,

  // Queue side
  output logic      push_o,
  output tx_byte_t  push_byte_o,
  input  logic      fifo_full_i,
  input  fifo_cnt_t fifo_cnt_i,

  // Serializer status
  input  logic      ser_busy_i,

  // Test result
  output logic      test_done_o,
  output logic      test_pass_o,
  output hdata_t    test_code_o
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  logic        addr_valid;
  region_e     addr_region;
  ahb_dphase_t dp_q;

  // First cycle of ERROR already given
  logic        err_q;
  logic        err_first;
  logic        wait_full;

  // Data phase qualifiers
  logic        dp_wr_tx;
  logic        dp_wr_tohost;
  logic        dp_read;

  hdata_t      tohost_q;
  logic        done_q;
  logic        pass_q;

  //////////////////////////////
  // Address phase
  //////////////////////////////

  // Only NONSEQ and SEQ carry a transfer, bursts run as single beats
  assign addr_valid = HSEL_i && HREADY_i && (HTRANS_i == NONSEQ || HTRANS_i == SEQ);

  // Word address compare against the map
  always_comb begin
    if (HSIZE_i > HSIZE_WORD) begin
      // Wider than a word, nothing here answers that
      addr_region = REG_NONE;
    end else if (HADDR_i[31:2] == TOHOST_ADDR[31:2]) begin
      addr_region = REG_TOHOST;
    end else if (HADDR_i[31:2] == UART_TX_ADDR[31:2]) begin
      addr_region = REG_UART_TX;
    end else if (HADDR_i[31:2] == UART_STAT_ADDR[31:2]) begin
      addr_region = REG_UART_STAT;
    end else begin
      addr_region = REG_NONE;
    end
  end

  // Register the phase, held while the bus is stalled
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      dp_q.valid  <= 1'b0;
      dp_q.write  <= 1'b0;
      dp_q.region <= REG_NONE;
    end else if (HREADY_i) begin
      dp_q.valid  <= addr_valid;
      dp_q.write  <= HWRITE_i;
      dp_q.region <= addr_region;
    end
  end

  //////////////////////////////
  // Data phase response
  //////////////////////////////

  // ERROR cycle one: not ready, response high
  assign err_first = dp_q.valid && (dp_q.region == REG_NONE) && !err_q;

  // UART write stalls until the queue has room
  assign dp_wr_tx  = dp_q.valid && dp_q.write && (dp_q.region == REG_UART_TX);
  assign wait_full = dp_wr_tx && fifo_full_i;

  assign HREADYOUT_o = !(err_first || wait_full);
  assign HRESP_o     = dp_q.valid && (dp_q.region == REG_NONE);

  // Cycle two of ERROR follows directly
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_first;
    end
  end

  //////////////////////////////
  // Writes
  //////////////////////////////

  // Push in the ready cycle of the write, low byte only
  assign push_o      = dp_wr_tx && !fifo_full_i;
  assign push_byte_o = HWDATA_i[7:0];

  assign dp_wr_tohost = dp_q.valid && dp_q.write && (dp_q.region == REG_TOHOST);

  // TOHOST word and verdict, done is sticky
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      tohost_q <= '0;
      done_q   <= 1'b0;
      pass_q   <= 1'b0;
    end else if (dp_wr_tohost) begin
      tohost_q <= HWDATA_i;
      done_q   <= 1'b1;
      pass_q   <= (HWDATA_i == hdata_t'(1));
    end
  end

  assign test_done_o = done_q;
  assign test_pass_o = pass_q;
  // Bit 0 is the done marker, the rest is the code
  assign test_code_o = tohost_q >> 1;

  //////////////////////////////
  // Reads
  //////////////////////////////

  assign dp_read = dp_q.valid && !dp_q.write;

  always_comb begin
    HRDATA_o = '0;
    if (dp_read) begin
      case (dp_q.region)
        // Status: busy, full, fill count
        REG_UART_STAT: HRDATA_o = {27'd0, ser_busy_i, fifo_full_i, fifo_cnt_i};
        REG_TOHOST:    HRDATA_o = tohost_q;
        default:       HRDATA_o = '0;
      endcase
    end
  end

endmodule

//--- hw/ahb_mmio_top.sv
// Host catcher top level
// AHB-Lite decoder feeding a byte queue that drains through
// the UART serializer onto the serial line
module ahb_mmio_top
  import mmio_pkg::*;
(
  input  logic    HCLK,
  input  logic    rst_n_i,

  // AHB-Lite slave
  input  logic    HSEL_i,
  input  haddr_t  HADDR_i,
  input  htrans_e HTRANS_i,
  input  logic    HWRITE_i,
  input  hsize_t  HSIZE_i,
  input  hdata_t  HWDATA_i,
  input  logic    HREADY_i,
  output logic    HREADYOUT_o,
  output logic    HRESP_o,
  output hdata_t  HRDATA_o,

  // Serial line
  output logic    uart_txd_o,

  // Test result
  output logic    test_done_o,
  output logic    test_pass_o,
  output hdata_t  test_code_o
);

  //////////////////////////////
  // Internal wires
  //////////////////////////////

  // Decoder to queue
  logic      push;
  tx_byte_t  push_byte;
  logic      fifo_full;
  fifo_cnt_t fifo_cnt;

  // Queue to serializer
  logic      fifo_empty;
  tx_byte_t  head_byte;
  logic      pop;
  logic      ser_busy;

  // Bus decoder, producer
  ahb_mmio_decoder u_decoder (
    .HCLK        (HCLK),
    .rst_n_i     (rst_n_i),
    .HSEL_i      (HSEL_i),
    .HADDR_i     (HADDR_i),
    .HTRANS_i    (HTRANS_i),
    .HWRITE_i    (HWRITE_i),
    .HSIZE_i     (HSIZE_i),
    .HWDATA_i    (HWDATA_i),
    .HREADY_i    (HREADY_i),
    .HREADYOUT_o (HREADYOUT_o),
    .HRESP_o     (HRESP_o),
    .HRDATA_o    (HRDATA_o),
    .push_o      (push),
    .push_byte_o (push_byte),
    .fifo_full_i (fifo_full),
    .fifo_cnt_i  (fifo_cnt),
    .ser_busy_i  (ser_busy),
    .test_done_o (test_done_o),
    .test_pass_o (test_pass_o),
    .test_code_o (test_code_o)
  );

  // Byte queue
  tx_byte_fifo u_fifo (
    .HCLK        (HCLK),
    .rst_n_i     (rst_n_i),
    .push_i      (push),
    .push_byte_i (push_byte),
    .pop_i       (pop),
    .head_byte_o (head_byte),
    .empty_o     (fifo_empty),
    .full_o      (fifo_full),
    .count_o     (fifo_cnt)
  );

  // Line driver, consumer
  uart_serializer u_serializer (
    .HCLK        (HCLK),
    .rst_n_i     (rst_n_i),
    .empty_i     (fifo_empty),
    .head_byte_i (head_byte),
    .pop_o       (pop),
    .busy_o      (ser_busy),
    .uart_txd_o  (uart_txd_o)
  );

endmodule

//--- hw/mmio_pkg.sv
// Host catcher MMIO package
// Bus types, address map, queue sizing, serial bit timing
// and the state encodings shared by the decoder, the queue
// and the serializer
package mmio_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  // AHB-Lite address and data words
  typedef logic [31:0] haddr_t;
  typedef logic [31:0] hdata_t;
  typedef logic [2:0]  hsize_t;

  // Serial payload byte
  typedef logic [7:0] tx_byte_t;

  // Transfer type on HTRANS
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Widest access the slave answers, one 32-bit word
  localparam hsize_t HSIZE_WORD = 3'b010;

  //////////////////////////////
  // Address map
  //////////////////////////////

  localparam haddr_t TOHOST_ADDR    = 32'h8000_1000;
  localparam haddr_t UART_TX_ADDR   = 32'h8000_1080;
  localparam haddr_t UART_STAT_ADDR = 32'h8000_1084;

  // Decoded target of one transfer
  typedef enum logic [1:0] {
    REG_TOHOST    = 2'd0,
    REG_UART_TX   = 2'd1,
    REG_UART_STAT = 2'd2,
    REG_NONE      = 2'd3
  } region_e;

  // Address phase kept for the data phase
  typedef struct packed {
    logic    valid;
    logic    write;
    region_e region;
  } ahb_dphase_t;

  //////////////////////////////
  // Byte queue
  //////////////////////////////

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // Fill level, 0 up to FIFO_DEPTH
  typedef logic [2:0] fifo_cnt_t;

  //////////////////////////////
  // Serializer
  //////////////////////////////

  // HCLK cycles per serial bit
  localparam int BIT_CYCLES = 8;
  localparam int BIT_CNT_W  = $clog2(BIT_CYCLES);

  typedef enum logic [1:0] {
    SER_IDLE  = 2'd0,
    SER_START = 2'd1,
    SER_DATA  = 2'd2,
    SER_STOP  = 2'd3
  } ser_state_e;

endpackage

//--- hw/tx_byte_fifo.sv
// Transmit byte queue
// Circular buffer of FIFO_DEPTH bytes between the bus decoder
// and the serializer, with empty, full and fill count
module tx_byte_fifo
  import mmio_pkg::*;
(
  input  logic      HCLK,
  input  logic      rst_n_i,

  // Write side
  input  logic      push_i,
  input  tx_byte_t  push_byte_i,

  // Read side
  input  logic      pop_i,
  output tx_byte_t  head_byte_o,

  // Levels
  output logic      empty_o,
  output logic      full_o,
  output fifo_cnt_t count_o
);

  //////////////////////////////
  // Storage and pointers
  //////////////////////////////

  tx_byte_t                mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0]   wr_ptr_q;
  logic [FIFO_PTR_W-1:0]   rd_ptr_q;
  fifo_cnt_t               cnt_q;

  // Qualified requests, overflow and underflow dropped
  logic                    do_push;
  logic                    do_pop;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == fifo_cnt_t'(FIFO_DEPTH));
  assign count_o = cnt_q;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Oldest byte is always at the read pointer
  assign head_byte_o = mem_q[rd_ptr_q];

  // Byte storage
  always_ff @(posedge HCLK) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_byte_i;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Fill count
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        // Both or neither, level unchanged
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

//--- hw/uart_serializer.sv
// UART transmit serializer
// Pops bytes from the queue and shifts 8N1 frames onto the
// serial line, BIT_CYCLES clocks per bit, LSB first
module uart_serializer
  import mmio_pkg::*;
(
  input  logic     HCLK,
  input  logic     rst_n_i,

  // Queue side
  input  logic     empty_i,
  input  tx_byte_t head_byte_i,
  output logic     pop_o,

  // Status and line
  output logic     busy_o,
  output logic     uart_txd_o
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  ser_state_e           state_q;
  logic [BIT_CNT_W-1:0] bit_cnt_q;
  logic [2:0]           bit_idx_q;
  tx_byte_t             shift_q;
  logic                 txd_q;

  // Last clock of the current bit
  logic                 bit_end;

  assign bit_end = (bit_cnt_q == BIT_CNT_W'(BIT_CYCLES - 1));

  // Take a byte when idle, or right after a stop bit
  assign pop_o = !empty_i &&
                 ((state_q == SER_IDLE) || (state_q == SER_STOP && bit_end));

  assign busy_o     = (state_q != SER_IDLE);
  assign uart_txd_o = txd_q;

  // Bit period counter, restarts at each bit
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      bit_cnt_q <= '0;
    end else if (state_q == SER_IDLE || bit_end) begin
      bit_cnt_q <= '0;
    end else begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  //////////////////////////////
  // Frame FSM
  //////////////////////////////

  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      state_q   <= SER_IDLE;
      bit_idx_q <= '0;
      txd_q     <= 1'b1;
    end else begin
      case (state_q)
        SER_IDLE: begin
          if (pop_o) begin
            // Start bit goes out with the pop
            state_q <= SER_START;
            txd_q   <= 1'b0;
          end
        end
        SER_START: begin
          if (bit_end) begin
            state_q   <= SER_DATA;
            bit_idx_q <= '0;
            txd_q     <= shift_q[0];
          end
        end
        SER_DATA: begin
          if (bit_end) begin
            if (bit_idx_q == 3'd7) begin
              state_q <= SER_STOP;
              txd_q   <= 1'b1;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
              txd_q     <= shift_q[0];
            end
          end
        end
        SER_STOP: begin
          if (bit_end) begin
            // Back-to-back frame or back to idle
            state_q <= pop_o ? SER_START : SER_IDLE;
            txd_q   <= !pop_o;
          end
        end
        default: state_q <= SER_IDLE;
      endcase
    end
  end

  // Payload shifter, next bit always at position 0
  always_ff @(posedge HCLK) begin
    if (pop_o) begin
      shift_q <= head_byte_i;
    end else if (bit_end && (state_q == SER_START || state_q == SER_DATA)) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

//--- test/ahb_mmio_chk.sv
// Protocol assertions for the host catcher
// Watches the two-cycle ERROR response, the idle serial
// line and the sticky test_done flag
module ahb_mmio_chk (
  input logic HCLK,
  input logic rst_n_i,
  input logic hreadyout_i,
  input logic hresp_i,
  input logic uart_txd_i,
  input logic ser_busy_i,
  input logic test_done_i
);

  // Failed assertions so far
  int fail_cnt = 0;

  //////////////////////////////
  // Bus rules
  //////////////////////////////

  // ERROR cycle one is always followed by ready ERROR
  a_err_two_cycle: assert property (
    @(posedge HCLK) disable iff (!rst_n_i)
      (hresp_i && !hreadyout_i) |=> (hresp_i && hreadyout_i)
  ) else begin
    fail_cnt++;
    $error("ERROR response cycle one not followed by ready ERROR cycle");
  end

  //////////////////////////////
  // Line and result rules
  //////////////////////////////

  // Idle serializer holds the line at mark
  a_idle_line_high: assert property (
    @(posedge HCLK) disable iff (!rst_n_i)
      !ser_busy_i |-> uart_txd_i
  ) else begin
    fail_cnt++;
    $error("Serial line low while serializer idle");
  end

  // Sticky done
  a_done_sticky: assert property (
    @(posedge HCLK) disable iff (!rst_n_i)
      test_done_i |=> test_done_i
  ) else begin
    fail_cnt++;
    $error("test_done fell after being set");
  end

endmodule

bind ahb_mmio_top ahb_mmio_chk u_chk (
  .HCLK        (HCLK),
  .rst_n_i     (rst_n_i),
  .hreadyout_i (HREADYOUT_o),
  .hresp_i     (HRESP_o),
  .uart_txd_i  (uart_txd_o),
  .ser_busy_i  (ser_busy),
  .test_done_i (test_done_o)
);

//--- test/ahb_mmio_tb.sv
// Directed testbench for the host catcher
// Drives AHB-Lite single beats, decodes the serial line
// and checks the queue, ERROR response and TOHOST flags
module ahb_mmio_tb
  import mmio_pkg::*;
();

  //////////////////////////////
  // Bench constants
  //////////////////////////////

  localparam int      CLK_PERIOD    = 100;
  localparam int      DRIVE_DLY     = 10;
  localparam int      RESET_CYCLES  = 4;
  localparam int      N_SINGLE      = 4;
  localparam int      N_BURST       = 6;
  localparam haddr_t  UNMAPPED_ADDR = 32'h8000_2000;
  // Ten bits per frame plus room for the bus traffic
  localparam longint  WATCHDOG_TIME =
    longint'(N_SINGLE + N_BURST) * 10 * BIT_CYCLES * CLK_PERIOD + 100_000;

  logic      HCLK;
  logic      rst_n;
  logic      hsel;
  haddr_t    haddr;
  htrans_e   htrans;
  logic      hwrite;
  hsize_t    hsize;
  hdata_t    hwdata;
  logic      hready;
  logic      hreadyout;
  logic      hresp;
  hdata_t    hrdata;
  logic      uart_txd;
  logic      test_done;
  logic      test_pass;
  hdata_t    test_code;

  int        errors = 0;
  int        checks = 0;
  // Wait cycles and {first, last} HRESP of the last transfer
  int        xfer_waits;
  logic [1:0] xfer_resp;

  // Bytes and stop bits seen on the line
  tx_byte_t  rx_q[$];
  logic      stop_q[$];

  // Bus ready comes straight from the only slave
  assign hready = rst_n ? hreadyout : 1'b1;

  ahb_mmio_top UUT (
    .HCLK        (HCLK),
    .rst_n_i     (rst_n),
    .HSEL_i      (hsel),
    .HADDR_i     (haddr),
    .HTRANS_i    (htrans),
    .HWRITE_i    (hwrite),
    .HSIZE_i     (hsize),
    .HWDATA_i    (hwdata),
    .HREADY_i    (hready),
    .HREADYOUT_o (hreadyout),
    .HRESP_o     (hresp),
    .HRDATA_o    (hrdata),
    .uart_txd_o  (uart_txd),
    .test_done_o (test_done),
    .test_pass_o (test_pass),
    .test_code_o (test_code)
  );

  initial HCLK = 1'b0;
  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_byte(input tx_byte_t got, input tx_byte_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input hdata_t got, input hdata_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // AHB driver
  //////////////////////////////

  task automatic bus_idle();
    hsel   = 1'b0;
    htrans = IDLE;
    hwrite = 1'b0;
  endtask

  // Address phase then data phase until HREADYOUT is high
  task automatic ahb_xfer(input haddr_t addr, input logic write, input hdata_t wdata,
                          output hdata_t rdata);
    @(posedge HCLK);
    #DRIVE_DLY;
    hsel   = 1'b1;
    haddr  = addr;
    htrans = NONSEQ;
    hwrite = write;
    hsize  = HSIZE_WORD;
    @(negedge HCLK);
    while (!hreadyout) @(negedge HCLK);
    @(posedge HCLK);
    #DRIVE_DLY;
    bus_idle();
    if (write) begin
      hwdata = wdata;
    end
    xfer_waits = 0;
    @(negedge HCLK);
    xfer_resp[1] = hresp;
    while (!hreadyout) begin
      xfer_waits++;
      @(negedge HCLK);
    end
    xfer_resp[0] = hresp;
    rdata = hrdata;
  endtask

  task automatic ahb_write(input haddr_t addr, input hdata_t data);
    hdata_t ignored;
    ahb_xfer(addr, 1'b1, data, ignored);
  endtask

  task automatic ahb_read(input haddr_t addr, output hdata_t data);
    ahb_xfer(addr, 1'b0, '0, data);
  endtask

  //////////////////////////////
  // Serial line helpers
  //////////////////////////////

  // Decode 8N1 frames by sampling mid bit on the falling clock
  initial begin : line_monitor
    tx_byte_t rx_byte;
    logic     stop_bit;
    @(posedge rst_n);
    forever begin
      @(negedge uart_txd);
      repeat (BIT_CYCLES / 2) @(negedge HCLK);
      if (uart_txd !== 1'b0) begin
        errors++;
        $display("Line monitor: start bit did not stay low at %0t", $time);
      end
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYCLES) @(negedge HCLK);
        rx_byte[i] = uart_txd;
      end
      repeat (BIT_CYCLES) @(negedge HCLK);
      stop_bit = uart_txd;
      rx_q.push_back(rx_byte);
      stop_q.push_back(stop_bit);
    end
  end

  task automatic wait_rx(input int n);
    int cycles;
    cycles = 0;
    while (rx_q.size() < n && cycles < n * 12 * BIT_CYCLES + 200) begin
      @(posedge HCLK);
      cycles++;
    end
    if (rx_q.size() < n) begin
      errors++;
      $display("Serial line: only %0d of %0d bytes arrived", rx_q.size(), n);
    end
  endtask

  // Poll status until queue empty and serializer idle
  task automatic wait_line_idle();
    hdata_t stat;
    int     polls;
    polls = 0;
    do begin
      ahb_read(UART_STAT_ADDR, stat);
      polls++;
    end while (stat[4:0] != 5'd0 && polls < 400);
    if (stat[4:0] != 5'd0) begin
      errors++;
      $display("Serializer never went idle, status %08h", stat);
    end
  endtask

  task automatic expect_rx(input tx_byte_t exp, input string what);
    tx_byte_t got;
    logic     stop_bit;
    if (rx_q.size() == 0) begin
      errors++;
      $display("No serial byte for %s", what);
    end else begin
      got      = rx_q.pop_front();
      stop_bit = stop_q.pop_front();
      check_byte(got, exp, what);
      check_bit(stop_bit, 1'b1, {what, " stop bit"});
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic reset_values();
    hdata_t stat;
    @(negedge HCLK);
    check_bit(uart_txd, 1'b1, "line idle after reset");
    check_bit(hreadyout, 1'b1, "HREADYOUT after reset");
    check_bit(hresp, 1'b0, "HRESP after reset");
    check_bit(test_done, 1'b0, "test_done after reset");
    check_bit(test_pass, 1'b0, "test_pass after reset");
    ahb_read(UART_STAT_ADDR, stat);
    check_word(stat, 32'd0, "status after reset");
  endtask

  task automatic single_bytes();
    hdata_t data;
    for (int i = 0; i < N_SINGLE; i++) begin
      data = $urandom();
      ahb_write(UART_TX_ADDR, data);
      check_bit(xfer_resp[0], 1'b0, "UART_TX write OKAY");
      wait_rx(1);
      wait_line_idle();
      expect_rx(data[7:0], "single byte");
    end
  endtask

  task automatic back_pressure();
    tx_byte_t  sent[N_BURST];
    hdata_t    data;
    hdata_t    stat;
    fifo_cnt_t cnt;
    int        total_waits;
    total_waits = 0;
    for (int i = 0; i < N_BURST; i++) begin
      data    = $urandom();
      sent[i] = data[7:0];
      ahb_write(UART_TX_ADDR, data);
      total_waits += xfer_waits;
      check_bit(xfer_resp[0], 1'b0, "burst write OKAY");
      // Peek once the queue should be near its limit
      if (i == FIFO_DEPTH) begin
        ahb_read(UART_STAT_ADDR, stat);
        cnt = stat[2:0];
        check_bit(cnt <= fifo_cnt_t'(FIFO_DEPTH), 1'b1, "count within depth");
        check_bit(stat[3], cnt == fifo_cnt_t'(FIFO_DEPTH), "full flag matches count");
      end
    end
    check_bit(total_waits > 0, 1'b1, "wait state while full");
    wait_rx(N_BURST);
    for (int i = 0; i < N_BURST; i++) begin
      expect_rx(sent[i], "burst byte");
    end
    wait_line_idle();
  endtask

  task automatic unmapped_access();
    hdata_t stat_before;
    hdata_t stat_after;
    hdata_t rd;
    ahb_read(UART_STAT_ADDR, stat_before);
    ahb_read(UNMAPPED_ADDR, rd);
    check_bit(xfer_waits == 1, 1'b1, "unmapped read one wait cycle");
    check_bit(xfer_resp[1], 1'b1, "unmapped read ERROR first cycle");
    check_bit(xfer_resp[0], 1'b1, "unmapped read ERROR second cycle");
    // Value 1 would look like a pass if it leaked into TOHOST
    ahb_write(UNMAPPED_ADDR, 32'd1);
    check_bit(xfer_waits == 1, 1'b1, "unmapped write one wait cycle");
    check_bit(xfer_resp[1], 1'b1, "unmapped write ERROR first cycle");
    check_bit(xfer_resp[0], 1'b1, "unmapped write ERROR second cycle");
    ahb_read(UART_STAT_ADDR, stat_after);
    check_word(stat_after, stat_before, "status unchanged by unmapped access");
    check_bit(test_done, 1'b0, "test_done untouched");
    check_bit(test_pass, 1'b0, "test_pass untouched");
  endtask

  task automatic tohost_result();
    hdata_t rd;
    ahb_write(TOHOST_ADDR, 32'd7);
    check_bit(test_done, 1'b0, "done not before data phase ends");
    @(negedge HCLK);
    check_bit(test_done, 1'b1, "done after fail code");
    check_bit(test_pass, 1'b0, "no pass on code 7");
    check_word(test_code, 32'd3, "fail code");
    ahb_read(TOHOST_ADDR, rd);
    check_word(rd, 32'd7, "TOHOST readback");
    ahb_write(TOHOST_ADDR, 32'd1);
    @(negedge HCLK);
    check_bit(test_done, 1'b1, "done stays set");
    check_bit(test_pass, 1'b1, "pass on value 1");
    check_word(test_code, 32'd0, "pass code");
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : main
    void'($urandom(32'hbc46e501));
    rst_n  = 1'b0;
    haddr  = '0;
    hsize  = HSIZE_WORD;
    hwdata = '0;
    bus_idle();
    repeat (RESET_CYCLES) @(posedge HCLK);
    #DRIVE_DLY;
    rst_n = 1'b1;
    reset_values();
    single_bytes();
    back_pressure();
    unmapped_access();
    tohost_result();
    errors += UUT.u_chk.fail_cnt;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    $display("Watchdog expired at %0t, tests did not complete", $time);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- vlog.f
hw/mmio_pkg.sv
hw/tx_byte_fifo.sv
hw/uart_serializer.sv
hw/ahb_mmio_decoder.sv
hw/ahb_mmio_top.sv
test/ahb_mmio_chk.sv
test/ahb_mmio_tb.sv
